// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= game_top_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/game_top_tb.sv ====
`timescale 1ns/1ps

module game_top_tb;

    import game_pkg::*;

    localparam int addr_width       = 17;
    localparam int region_bits      = 10;
    localparam int color_width      = 3;
    localparam int region_size      = 1 << region_bits;
    localparam int canvas_used      = stage_count * region_size;
    localparam int writes_per_frame = 12;
    localparam int gapped_frames    = 5;

    logic                   clock;
    logic                   resetn;
    logic                   enable;
    logic                   start_key;
    logic [addr_width-1:0]  read_addr;
    game_phase_t            phase;
    logic                   wr_en;
    logic [addr_width-1:0]  wr_addr;
    logic [color_width-1:0] wr_color;
    logic [color_width-1:0] read_data;

    int check_errors = 0;
    int timeout_errors = 0;
    int write_count = 0; // Writes seen since reset, all frames

    // Last expected color per canvas address
    logic [color_width-1:0] scoreboard [canvas_used];
    bit                     written [canvas_used];

    game_top #(
        .addr_width  (addr_width),
        .region_bits (region_bits),
        .color_width (color_width)
    ) u_dut (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (enable),
        .start_key (start_key),
        .read_addr (read_addr),
        .phase     (phase),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_color  (wr_color),
        .read_data (read_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // Write n of frame f, packed as address over color
    function automatic logic [addr_width+color_width-1:0] expected_write(
        input int frame_index,
        input int n
    );
        int                     address;
        logic [color_width-1:0] color;
        address = n * region_size + (frame_index % region_size);
        color   = color_width'((n % 7) + 1);
        return {addr_width'(address), color};
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            check_errors++;
            $display("FAILED at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    // Next drive point, shortly after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic wait_for_phase(input game_phase_t target, input int limit,
                                  output int cycles);
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (phase != target && cycles < limit);
        if (phase != target) begin
            timeout_errors++;
            $display("Timeout at %0t ns: phase never reached %s within %0d cycles",
                     $time, target.name(), limit);
        end
    endtask

    // Key press from greeting
    task automatic start_game();
        int cycles;
        enable    = 1'b1;
        start_key = 1'b1;
        wait_for_phase(phase_playing, 4, cycles);
        start_key = 1'b0;
        check_value("cycles to playing", 1, cycles);
    endtask

    // Play until game over, enable drops for single cycles at random
    task automatic run_gapped_frame(input int limit, output int cycles);
        bit dropped;
        dropped = 1'b0;
        cycles  = 0;
        do begin
            if (!dropped && ($urandom % 4 == 0)) begin
                enable  = 1'b0;
                dropped = 1'b1;
            end else begin
                enable  = 1'b1;
                dropped = 1'b0;
            end
            next_cycle();
            cycles++;
        end while (phase != phase_game_over && cycles < limit);
        enable = 1'b1;
        if (phase != phase_game_over) begin
            timeout_errors++;
            $display("Timeout at %0t ns: gapped frame did not reach game over", $time);
        end
    endtask

    // Every write is compared in order against the reference
    always @(negedge clock) begin : compare_writes
        logic [addr_width+color_width-1:0] expected;
        int                                exp_addr;
        if (resetn && wr_en) begin
            expected = expected_write(write_count / writes_per_frame,
                                      write_count % writes_per_frame);
            exp_addr = int'(expected[addr_width+color_width-1:color_width]);
            check_value("wr_addr", exp_addr, int'(wr_addr));
            check_value("wr_color", int'(expected[color_width-1:0]), int'(wr_color));
            assert (phase == phase_playing) else begin
                check_errors++;
                $display("Write strobe at %0t ns while not in the playing phase", $time);
            end
            scoreboard[exp_addr] = expected[color_width-1:0];
            written[exp_addr]    = 1'b1;
            write_count++;
        end
    end

    initial begin : main_sequence
        int cycles;
        int frame_start;
        int reads;
        void'($urandom(32'h6403_601d));
        resetn    = 1'b0;
        enable    = 1'b0;
        start_key = 1'b0;
        read_addr = '0;
        repeat (10) @(posedge clock);
        #10;
        resetn = 1'b1;

        // Idle greeting, key ignored without enable
        @(negedge clock);
        check_value("phase", int'(phase_greeting), int'(phase));
        check_value("wr_en", 0, int'(wr_en));
        next_cycle();
        enable = 1'b1;
        repeat (20) begin
            next_cycle();
            check_value("phase", int'(phase_greeting), int'(phase));
        end
        enable    = 1'b0;
        start_key = 1'b1;
        repeat (20) begin
            next_cycle();
            check_value("phase", int'(phase_greeting), int'(phase));
        end
        start_key = 1'b0;

        // One full frame with enable held high
        frame_start = write_count;
        start_game();
        wait_for_phase(phase_game_over, 40, cycles);
        check_value("cycles in playing", 14, cycles);
        check_value("writes in frame", writes_per_frame, write_count - frame_start);

        // Game over holds until the key, then back to greeting
        frame_start = write_count;
        repeat (10) begin
            next_cycle();
            check_value("phase", int'(phase_game_over), int'(phase));
        end
        start_key = 1'b1;
        wait_for_phase(phase_greeting, 4, cycles);
        start_key = 1'b0;
        check_value("cycles to greeting", 1, cycles);
        repeat (5) next_cycle();
        check_value("writes outside playing", 0, write_count - frame_start);

        for (int f = 1; f <= gapped_frames; f++) begin
            frame_start = write_count;
            start_game();
            run_gapped_frame(60, cycles);
            check_value("writes in frame", writes_per_frame, write_count - frame_start);
            check_value("phase", int'(phase_game_over), int'(phase));
            start_key = 1'b1;
            wait_for_phase(phase_greeting, 4, cycles);
            start_key = 1'b0;
        end

        // Read back every written pixel
        enable = 1'b0;
        reads  = 0;
        for (int a = 0; a < canvas_used; a++) begin
            if (written[a]) begin
                read_addr = addr_width'(a);
                next_cycle(); // Registered read port
                check_value("read_data", int'(scoreboard[a]), int'(read_data));
                reads++;
            end
        end
        check_value("addresses written", (gapped_frames + 1) * writes_per_frame, reads);

        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== source/canvas_ram.sv ====
`timescale 1ns/1ps

module canvas_ram #(
    parameter int addr_width  = 17,
    parameter int color_width = 3
) (
    input  logic                   clock,
    input  logic                   wr_en,
    input  logic [addr_width-1:0]  wr_addr,
    input  logic [color_width-1:0] wr_color,
    input  logic [addr_width-1:0]  read_addr,
    output logic [color_width-1:0] read_data
);

    localparam int depth = 1 << addr_width;

    logic [color_width-1:0] mem [depth];

    // Write port
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_color;
        end
    end

    // Registered read, data one cycle after address
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

// ==== source/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  frame_run,
    output game_pkg::frame_stage_t stage,
    output logic                  stage_write,
    output logic                  frame_done
);

    import game_pkg::*;

    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_stage = 2'd1,
        seq_done  = 2'd2
    } seq_state_t;

    seq_state_t seq_state;

    // One step per run cycle: idle, twelve stages, done
    always_ff @(posedge clock) begin
        if (!resetn) begin
            seq_state <= seq_idle;
            stage     <= stage_clear_screen;
        end else if (frame_run) begin
            case (seq_state)
                seq_idle: begin
                    seq_state <= seq_stage;
                    stage     <= stage_clear_screen; // Every frame starts at stage 0
                end
                seq_stage: begin
                    if (stage == stage_update_vga) begin
                        seq_state <= seq_done;
                    end else begin
                        stage <= frame_stage_t'(stage + 4'd1);
                    end
                end
                seq_done: begin
                    seq_state <= seq_idle;
                end
                default: begin
                    seq_state <= seq_idle;
                end
            endcase
        end
    end

    // Each stage finishes in its single enabled cycle
    assign stage_write = frame_run && (seq_state == seq_stage);
    assign frame_done  = (seq_state == seq_done);

    // Writes only come from a stage state with a legal stage index
    a_write_in_stage: assert property (
        @(posedge clock) disable iff (!resetn)
        stage_write |-> (seq_state == seq_stage) && (int'(stage) < stage_count)
    ) else $error("stage write outside a stage state");

endmodule

// ==== source/game_phase_fsm.sv ====
`timescale 1ns/1ps

module game_phase_fsm (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 enable,
    input  logic                 start_key,
    input  logic                 frame_done,
    output game_pkg::game_phase_t phase,
    output logic                 frame_run
);

    import game_pkg::*;

    game_phase_t next_phase;

    // Phase register, frozen while enable is low
    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase <= phase_greeting;
        end else if (enable) begin
            phase <= next_phase;
        end
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            phase_greeting: begin
                if (start_key) begin
                    next_phase = phase_playing; // Key press starts a game
                end
            end
            phase_playing: begin
                if (frame_done) begin
                    next_phase = phase_game_over;
                end
            end
            phase_game_over: begin
                // Key press returns to the greeting screen
                if (start_key) begin
                    next_phase = phase_greeting;
                end
            end
            default: begin
                next_phase = phase_greeting;
            end
        endcase
    end

    // Sequencer may only step while playing and enabled
    assign frame_run = enable && (phase == phase_playing);

    // Phase register never leaves the three legal codes
    a_phase_legal: assert property (
        @(posedge clock) disable iff (!resetn)
        phase inside {phase_greeting, phase_playing, phase_game_over}
    ) else $error("phase register holds illegal code %0d", phase);

endmodule

// ==== source/game_pkg.sv ====
package game_pkg;

    // Top level game phases
    typedef enum logic [1:0] {
        phase_greeting  = 2'd0,
        phase_playing   = 2'd1,
        phase_game_over = 2'd2
    } game_phase_t;

    // Frame stages, visited in this order once per frame
    typedef enum logic [3:0] {
        stage_clear_screen            = 4'd0,
        stage_update_position         = 4'd1,
        stage_eat_food                = 4'd2,
        stage_update_ghost_directions = 4'd3,
        stage_update_ghost_positions  = 4'd4,
        stage_fill_screen             = 4'd5,
        stage_render_blocks           = 4'd6,
        stage_render_player           = 4'd7,
        stage_render_food             = 4'd8,
        stage_render_ghosts           = 4'd9,
        stage_ghost_collision         = 4'd10,
        stage_update_vga              = 4'd11
    } frame_stage_t;

    localparam int stage_count = 12;

    // Pixel color of a stage, cycles through codes 1 to 7
    function automatic logic [2:0] stage_color(input frame_stage_t stage);
        int code;
        code = (int'(stage) % 7) + 1;
        return 3'(code);
    endfunction

endpackage

// ==== source/game_top.sv ====
`timescale 1ns/1ps

module game_top #(
    parameter int addr_width  = 17,
    parameter int region_bits = 10,
    parameter int color_width = 3
) (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   enable,
    input  logic                   start_key,
    input  logic [addr_width-1:0]  read_addr,
    output game_pkg::game_phase_t  phase,
    output logic                   wr_en,
    output logic [addr_width-1:0]  wr_addr,
    output logic [color_width-1:0] wr_color,
    output logic [color_width-1:0] read_data
);

    import game_pkg::*;

    logic         frame_run;
    logic         frame_done;
    frame_stage_t stage;
    logic         stage_write;

    // Phase control, the only block that sees enable
    game_phase_fsm u_phase (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .start_key  (start_key),
        .frame_done (frame_done),
        .phase      (phase),
        .frame_run  (frame_run)
    );

    frame_sequencer u_sequencer (
        .clock       (clock),
        .resetn      (resetn),
        .frame_run   (frame_run),
        .stage       (stage),
        .stage_write (stage_write),
        .frame_done  (frame_done)
    );

    pixel_writer #(
        .addr_width  (addr_width),
        .region_bits (region_bits),
        .color_width (color_width)
    ) u_writer (
        .clock       (clock),
        .resetn      (resetn),
        .stage       (stage),
        .stage_write (stage_write),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_color    (wr_color)
    );

    // Canvas sees the same write port that leaves the top
    canvas_ram #(
        .addr_width  (addr_width),
        .color_width (color_width)
    ) u_canvas (
        .clock     (clock),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_color  (wr_color),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

// ==== source/pixel_writer.sv ====
`timescale 1ns/1ps

module pixel_writer #(
    parameter int addr_width  = 17,
    parameter int region_bits = 10,
    parameter int color_width = 3
) (
    input  logic                   clock,
    input  logic                   resetn,
    input  game_pkg::frame_stage_t stage,
    input  logic                   stage_write,
    output logic                   wr_en,
    output logic [addr_width-1:0]  wr_addr,
    output logic [color_width-1:0] wr_color
);

    import game_pkg::*;

    // One cursor per stage, wraps inside its own region
    logic [region_bits-1:0] cursor [stage_count];
    logic [addr_width-1:0]  region_base;
    logic [addr_width-1:0]  cursor_offset;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < stage_count; i++) begin
                cursor[i] <= '0;
            end
        end else if (stage_write) begin
            cursor[stage] <= cursor[stage] + 1'b1; // Natural wrap at region size
        end
    end

    // Stage index selects the region
    assign region_base   = addr_width'(stage) << region_bits;
    assign cursor_offset = addr_width'(cursor[stage]);

    assign wr_en    = stage_write;
    assign wr_addr  = region_base | cursor_offset;
    assign wr_color = color_width'(stage_color(stage));

    // Region index needs four bits above the cursor
    a_addr_fits: assert property (
        @(posedge clock) disable iff (!resetn)
        addr_width >= region_bits + 4
    ) else $error("addr_width %0d too small for region_bits %0d", addr_width, region_bits);

    // Writes stay inside the twelve stage regions
    a_addr_in_range: assert property (
        @(posedge clock) disable iff (!resetn)
        wr_en |-> (int'(wr_addr) < stage_count * (1 << region_bits))
    ) else $error("write address %0h outside stage regions", wr_addr);

endmodule

// ==== src.f ====
source/game_pkg.sv
source/game_phase_fsm.sv
source/frame_sequencer.sv
source/pixel_writer.sv
source/canvas_ram.sv
source/game_top.sv
sim/game_top_tb.sv
